//--- all.f
+incdir+.
rv_m_pkg.sv
div_pipe_pkg.sv
div_stage_if.sv
div_operand_prep.sv
div_stage.sv
div_result_fixup.sv
rv_div_unit.sv
tb_rv_div_unit.sv

//--- div_operand_prep.sv
`include "div_settings.svh"

module div_operand_prep
  import rv_m_pkg::*;
  import div_pipe_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  div_op_e              in_op,
  input  logic [`DIV_XLEN-1:0] in_rs1,
  input  logic [`DIV_XLEN-1:0] in_rs2,
  div_stage_if.src             out
);

  logic      op_signed;
  logic      op_rem;
  logic      dividend_neg;
  logic      divisor_neg;
  logic      divisor_zero;
  rv_word_t  abs_dividend;
  rv_word_t  abs_divisor;
  div_meta_t meta_next;

  // funct3 decode
  assign op_signed = (in_op == OP_DIV) || (in_op == OP_REM);
  assign op_rem    = (in_op == OP_REM) || (in_op == OP_REMU);

  // sign bits only matter for DIV and REM
  assign dividend_neg = op_signed && in_rs1[`DIV_XLEN-1];
  assign divisor_neg  = op_signed && in_rs2[`DIV_XLEN-1];
  assign divisor_zero = (in_rs2 == '0);

  // most negative value maps onto itself, which is correct read as unsigned
  assign abs_dividend = dividend_neg ? twos_neg(in_rs1) : in_rs1;
  assign abs_divisor  = divisor_neg ? twos_neg(in_rs2) : in_rs2;

  always_comb begin
    meta_next.want_rem      = op_rem;
    meta_next.neg_quot      = (dividend_neg != divisor_neg) && !divisor_zero;
    meta_next.neg_rem       = dividend_neg;
    meta_next.div_by_zero   = divisor_zero;
    meta_next.orig_dividend = in_rs1;
  end

  // whole pipeline moves together, so the input side just follows advance
  assign in_ready = out.advance;

  always_ff @(posedge clk) begin
    if (rst) begin
      out.valid <= 1'b0;
    end else if (out.advance) begin
      out.valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (out.advance) begin
      out.rem     <= '0;
      out.quot    <= abs_dividend;
      out.divisor <= abs_divisor;
      out.meta    <= meta_next;
    end
  end

  // only the four divide codes reach this unit
  a_op_legal: assert property (
    @(posedge clk) disable iff (rst)
    (in_valid && in_ready) |-> (in_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU})
  );

endmodule

//--- div_pipe_pkg.sv
`include "div_settings.svh"

package div_pipe_pkg;

  // per-operation flags that ride along with the operands
  // the divider stages never look inside, only the fixup stage does
  typedef struct packed {
    // select remainder instead of quotient
    logic                 want_rem;
    // signed op with differing signs and a nonzero divisor
    logic                 neg_quot;
    // signed op with a negative dividend
    logic                 neg_rem;
    logic                 div_by_zero;
    // needed for REM and REMU by zero
    logic [`DIV_XLEN-1:0] orig_dividend;
  } div_meta_t;

endpackage

//--- div_result_fixup.sv
`include "div_settings.svh"

module div_result_fixup
  import rv_m_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  div_stage_if.snk             in,
  output logic                 out_valid,
  input  logic                 out_ready,
  output logic [`DIV_XLEN-1:0] out_result
);

  logic     advance;
  rv_word_t quot_fixed;
  rv_word_t rem_fixed;
  rv_word_t result_next;

  // RISC-V divide by zero: quotient all ones, remainder is the dividend
  always_comb begin
    if (in.meta.div_by_zero) begin
      quot_fixed = '1;
      rem_fixed  = in.meta.orig_dividend;
    end else begin
      quot_fixed = in.meta.neg_quot ? twos_neg(in.quot) : in.quot;
      rem_fixed  = in.meta.neg_rem ? twos_neg(in.rem) : in.rem;
    end
  end

  assign result_next = in.meta.want_rem ? rem_fixed : quot_fixed;

  // output slot free or being drained this cycle
  assign advance    = !out_valid || out_ready;
  assign in.advance = advance;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= in.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      out_result <= result_next;
    end
  end

  // a waiting result stays put until taken
  a_out_hold: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_result))
  );

endmodule

//--- div_settings.svh
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// operand and result width
`define DIV_XLEN 32

// quotient bits resolved by one divider stage
`define DIV_BITS_PER_STAGE 2

// divider depth, one stage per group of quotient bits
`define DIV_NUM_STAGES (`DIV_XLEN / `DIV_BITS_PER_STAGE)

`endif

//--- div_stage.sv
`include "div_settings.svh"

module div_stage (
  input  logic     clk,
  input  logic     rst,
  div_stage_if.snk up,
  div_stage_if.src down
);

  // one extra bit, the shifted remainder can reach twice the divisor
  logic [`DIV_XLEN:0]   rem_work;
  logic [`DIV_XLEN-1:0] quot_work;
  logic [`DIV_XLEN:0]   divisor_ext;

  assign divisor_ext = {1'b0, up.divisor};

  // restoring division, one quotient bit per iteration
  always_comb begin
    rem_work  = {1'b0, up.rem};
    quot_work = up.quot;
    for (int i = 0; i < `DIV_BITS_PER_STAGE; i++) begin
      // bring down the next dividend bit
      rem_work  = {rem_work[`DIV_XLEN-1:0], quot_work[`DIV_XLEN-1]};
      quot_work = {quot_work[`DIV_XLEN-2:0], 1'b0};
      if (rem_work >= divisor_ext) begin
        rem_work     = rem_work - divisor_ext;
        quot_work[0] = 1'b1;
      end
    end
  end

  // enable passes straight through toward prep
  assign up.advance = down.advance;

  always_ff @(posedge clk) begin
    if (rst) begin
      down.valid <= 1'b0;
    end else if (down.advance) begin
      down.valid <= up.valid;
    end
  end

  // payload loads on every advance, bubbles included
  always_ff @(posedge clk) begin
    if (down.advance) begin
      down.rem     <= rem_work[`DIV_XLEN-1:0];
      down.quot    <= quot_work;
      down.divisor <= up.divisor;
      down.meta    <= up.meta;
    end
  end

  // stalled by the output side, the stage holds its slot
  a_hold_on_stall: assert property (
    @(posedge clk) disable iff (rst)
    !down.advance |=> $stable(down.valid)
  );

endmodule

//--- div_stage_if.sv
`include "div_settings.svh"

interface div_stage_if
  import div_pipe_pkg::*;
();

  logic                 valid;
  // partial remainder, always below the divisor once registered
  logic [`DIV_XLEN-1:0] rem;
  // dividend bits still to consume on top, quotient bits shifted in at the bottom
  logic [`DIV_XLEN-1:0] quot;
  logic [`DIV_XLEN-1:0] divisor;
  div_meta_t            meta;
  // pipeline-wide enable, flows upstream from the fixup stage
  logic                 advance;

  modport src (
    output valid, rem, quot, divisor, meta,
    input  advance
  );

  modport snk (
    input  valid, rem, quot, divisor, meta,
    output advance
  );

endinterface

//--- run.sh
#!/bin/sh
# build with Verilator, run, then judge the run by its log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_rv_div_unit \
  -o sim_tb_rv_div_unit > build.log 2>&1 &&
  ./obj_dir/sim_tb_rv_div_unit > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } ||
  grep -q "All tests passed!" sim.log && { echo "PASS"; exit 0; } ||
  { echo "FAIL: no result in sim.log, see build.log"; exit 1; }

//--- rv_div_unit.sv
`include "div_settings.svh"

module rv_div_unit
  import rv_m_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  div_op_e              in_op,
  input  logic [`DIV_XLEN-1:0] in_rs1,
  input  logic [`DIV_XLEN-1:0] in_rs2,
  output logic                 out_valid,
  input  logic                 out_ready,
  output logic [`DIV_XLEN-1:0] out_result
);

  // link 0 leaves prep, link N enters fixup
  div_stage_if stage_link [`DIV_NUM_STAGES+1] ();

  div_operand_prep u_prep (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_op    (in_op),
    .in_rs1   (in_rs1),
    .in_rs2   (in_rs2),
    .out      (stage_link[0])
  );

  // unsigned divider, DIV_BITS_PER_STAGE quotient bits per stage
  for (genvar s = 0; s < `DIV_NUM_STAGES; s++) begin : gen_stage
    div_stage u_stage (
      .clk  (clk),
      .rst  (rst),
      .up   (stage_link[s]),
      .down (stage_link[s+1])
    );
  end

  div_result_fixup u_fixup (
    .clk        (clk),
    .rst        (rst),
    .in         (stage_link[`DIV_NUM_STAGES]),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
  );

endmodule

//--- rv_m_pkg.sv
`include "div_settings.svh"

package rv_m_pkg;

  // register value as seen by the M extension
  typedef logic [`DIV_XLEN-1:0] rv_word_t;

  // funct3 of the OP opcode when funct7 is 0000001
  typedef enum logic [2:0] {
    OP_DIV  = 3'd4,
    OP_DIVU = 3'd5,
    OP_REM  = 3'd6,
    OP_REMU = 3'd7
  } div_op_e;

  // two's complement negation, also gives |x| for negative x
  function automatic rv_word_t twos_neg(rv_word_t value);
    return ~value + rv_word_t'(1);
  endfunction

endpackage

//--- tb_rv_div_unit.sv
`include "div_settings.svh"

module tb_rv_div_unit
  import rv_m_pkg::*;
();

  localparam int NUM_OPS        = 600;
  localparam int STEADY_OPS     = 300;
  localparam int LATENCY        = `DIV_NUM_STAGES + 2;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 4 + 200;

  localparam logic [`DIV_XLEN-1:0] MOST_NEG  = {1'b1, {(`DIV_XLEN-1){1'b0}}};
  localparam logic [`DIV_XLEN-1:0] MINUS_ONE = '1;

  logic                 clk;
  logic                 rst;
  logic                 in_valid;
  logic                 in_ready;
  div_op_e              in_op;
  logic [`DIV_XLEN-1:0] in_rs1;
  logic [`DIV_XLEN-1:0] in_rs2;
  logic                 out_valid;
  logic                 out_ready;
  logic [`DIV_XLEN-1:0] out_result;

  integer seed = 32'hd6d3;

  // scoreboard state
  logic [`DIV_XLEN-1:0] exp_q[$];
  int                   accept_q[$];
  logic [`DIV_XLEN-1:0] exp_value;
  int                   accept_cycle;
  int                   cycle_count = 0;
  int                   error_count = 0;
  int                   accepted_count = 0;
  int                   delivered_count = 0;
  int                   zero_div_count = 0;
  int                   overflow_count = 0;
  int                   op_index = 0;
  bit                   steady_mode = 1'b0;
  bit                   hold_pending = 1'b0;
  logic [`DIV_XLEN-1:0] hold_value;

  rv_div_unit dut0 (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_op      (in_op),
    .in_rs1     (in_rs1),
    .in_rs2     (in_rs2),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // RISC-V M semantics with the special cases handled first
  function automatic logic [`DIV_XLEN-1:0] model_result(
    input div_op_e              op,
    input logic [`DIV_XLEN-1:0] a,
    input logic [`DIV_XLEN-1:0] b
  );
    logic signed [`DIV_XLEN-1:0] sa;
    logic signed [`DIV_XLEN-1:0] sb;
    logic [`DIV_XLEN-1:0]        q;
    logic [`DIV_XLEN-1:0]        r;
    logic                        is_signed;
    sa = a;
    sb = b;
    is_signed = (op == OP_DIV) || (op == OP_REM);
    if (b == '0) begin
      q = MINUS_ONE;
      r = a;
    end else if (is_signed && a == MOST_NEG && b == MINUS_ONE) begin
      q = MOST_NEG;
      r = '0;
    end else if (is_signed) begin
      // quotient truncates toward zero and the remainder follows the dividend
      q = sa / sb;
      r = sa % sb;
    end else begin
      q = a / b;
      r = a % b;
    end
    if (op == OP_REM || op == OP_REMU) begin
      return r;
    end else begin
      return q;
    end
  endfunction

  // roughly a quarter of operands land on the corner values
  function automatic logic [`DIV_XLEN-1:0] pick_operand();
    int pick;
    pick = {$random(seed)} % 12;
    case (pick)
      0:       return '0;
      1:       return MINUS_ONE;
      2:       return MOST_NEG;
      default: return $random(seed);
    endcase
  endfunction

  function automatic div_op_e pick_op();
    int pick;
    pick = {$random(seed)} % 4;
    case (pick)
      0:       return OP_DIV;
      1:       return OP_DIVU;
      2:       return OP_REM;
      default: return OP_REMU;
    endcase
  endfunction

  task automatic set_inputs(input div_op_e op, input logic [`DIV_XLEN-1:0] dividend,
                            input logic [`DIV_XLEN-1:0] divisor);
    in_op  = op;
    in_rs1 = dividend;
    in_rs2 = divisor;
  endtask

  // first few ops hit overflow and divide by zero for sure
  task automatic load_next_op();
    case (op_index)
      0: set_inputs(OP_DIV, MOST_NEG, MINUS_ONE);
      1: set_inputs(OP_REM, MOST_NEG, MINUS_ONE);
      2: set_inputs(OP_DIV, 32'h0000_1234, '0);
      3: set_inputs(OP_DIVU, 32'hdead_beef, '0);
      4: set_inputs(OP_REM, 32'hffff_fff9, '0);
      5: set_inputs(OP_REMU, 32'h0000_0055, '0);
      default: begin
        in_op  = pick_op();
        in_rs1 = pick_operand();
        in_rs2 = pick_operand();
      end
    endcase
    op_index++;
  endtask

  // offers count ops and keeps each one stable until it is taken
  task automatic drive_ops(input int count, input bit random_flow);
    int issued;
    bit accepted;
    issued = 0;
    while (issued < count) begin
      @(posedge clk);
      accepted = in_valid && in_ready;
      if (accepted) begin
        issued++;
      end
      #1;
      if (random_flow) begin
        out_ready = 1'($random(seed));
      end
      if (issued == count) begin
        in_valid = 1'b0;
      end else if (!in_valid || accepted) begin
        if (!random_flow || ({$random(seed)} % 4 != 0)) begin
          in_valid = 1'b1;
          load_next_op();
        end else begin
          in_valid = 1'b0;
        end
      end
    end
  endtask

  task automatic wait_drain();
    out_ready = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (exp_q.size() != 0);
  endtask

  // scoreboard, timeout and handshake checks sampled at the rising edge
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles with %0d results outstanding",
               cycle_count, exp_q.size());
      $display("Test failures found");
      $finish;
    end else if (!rst) begin
      // a waiting result must not move
      if (hold_pending) begin
        if (!out_valid) begin
          $display("out_valid dropped while a result was waiting at cycle %0d", cycle_count);
          error_count++;
        end else if (out_result !== hold_value) begin
          $display("Mismatch out_result held: expected 0x%08h got 0x%08h",
                   hold_value, out_result);
          error_count++;
        end
      end
      hold_pending = out_valid && !out_ready;
      hold_value   = out_result;

      if (steady_mode && !in_ready) begin
        $display("in_ready went low while out_ready was held high at cycle %0d", cycle_count);
        error_count++;
      end

      if (in_valid && in_ready) begin
        exp_q.push_back(model_result(in_op, in_rs1, in_rs2));
        accept_q.push_back(cycle_count);
        accepted_count++;
        if (in_rs2 == '0) begin
          zero_div_count++;
        end
        if (in_rs1 == MOST_NEG && in_rs2 == MINUS_ONE) begin
          overflow_count++;
        end
      end

      if (out_valid && out_ready) begin
        delivered_count++;
        if (exp_q.size() == 0) begin
          $display("result 0x%08h delivered with no operation outstanding", out_result);
          error_count++;
        end else begin
          exp_value    = exp_q.pop_front();
          accept_cycle = accept_q.pop_front();
          if (out_result !== exp_value) begin
            $display("Mismatch out_result: expected 0x%08h got 0x%08h",
                     exp_value, out_result);
            error_count++;
          end
          if (steady_mode && (cycle_count - accept_cycle) != LATENCY) begin
            $display("Mismatch latency: expected 0x%0h got 0x%0h",
                     LATENCY, cycle_count - accept_cycle);
            error_count++;
          end
        end
      end
    end
  end

  initial begin
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_op     = OP_DIV;
    in_rs1    = '0;
    in_rs2    = '0;
    out_ready = 1'b0;

    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;

    // idle state out of reset
    if (out_valid !== 1'b0) begin
      $display("Mismatch out_valid after reset: expected 0x0 got 0x%0h", out_valid);
      error_count++;
    end
    if (in_ready !== 1'b1) begin
      $display("Mismatch in_ready after reset: expected 0x1 got 0x%0h", in_ready);
      error_count++;
    end

    // full throughput with a fixed latency
    out_ready   = 1'b1;
    steady_mode = 1'b1;
    drive_ops(STEADY_OPS, 1'b0);
    wait_drain();
    steady_mode = 1'b0;

    // random back-pressure and bubbles
    drive_ops(NUM_OPS - STEADY_OPS, 1'b1);
    wait_drain();

    // nothing extra may come out afterwards
    repeat (30) @(posedge clk);
    #1;

    if (delivered_count != accepted_count) begin
      $display("%0d results delivered for %0d accepted operations",
               delivered_count, accepted_count);
      error_count++;
    end

    $display("errors=%0d accepted=%0d delivered=%0d div_by_zero=%0d overflow=%0d",
             error_count, accepted_count, delivered_count, zero_div_count, overflow_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
